// File: tb.f
verilog/rename_pkg.sv
verilog/map_table.sv
verilog/arch_map_table.sv
verilog/free_list.sv
verilog/rename_unit.sv
verif/rename_unit_tb.sv

// File: Bender.yml
package:
  name: rename_unit

sources:
  # shared package first, then the blocks, then the top level
  - files:
      - verilog/rename_pkg.sv
      - verilog/map_table.sv
      - verilog/arch_map_table.sv
      - verilog/free_list.sv
      - verilog/rename_unit.sv

  # testbench only in simulation builds
  - target: test
    files:
      - verif/rename_unit_tb.sv

// File: verif/rename_unit_tb.sv
// runs with LANES fixed at 2; rows run in order from reset and each row expects the previous state
`timescale 1ns/1ps

module rename_unit_tb
  import rename_pkg::*;
();

  localparam int LANES    = 2;
  localparam int max_rows = 32;

  logic                    clock;
  logic                    reset;
  logic      [LANES-1:0]   dest_valid;
  arch_idx_t [LANES-1:0]   dest_ar;
  arch_idx_t [LANES-1:0]   src1_ar;
  arch_idx_t [LANES-1:0]   src2_ar;
  logic      [LANES-1:0]   cdb_valid;
  phys_tag_t [LANES-1:0]   cdb_tag;
  logic      [LANES-1:0]   retire_valid;
  arch_idx_t [LANES-1:0]   retire_ar;
  phys_tag_t [LANES-1:0]   retire_tag;
  logic                    recover;
  phys_tag_t [LANES-1:0]   src1_tag;
  logic      [LANES-1:0]   src1_ready;
  phys_tag_t [LANES-1:0]   src2_tag;
  logic      [LANES-1:0]   src2_ready;
  phys_tag_t [LANES-1:0]   dest_tag;
  phys_tag_t [LANES-1:0]   told_tag;
  logic                    rename_stall;
  free_cnt_t               free_count;

  // stimulus columns with one entry per cycle
  string                   row_name [max_rows];
  logic      [LANES-1:0]   row_dv   [max_rows];
  arch_idx_t [LANES-1:0]   row_dar  [max_rows];
  arch_idx_t [LANES-1:0]   row_s1   [max_rows];
  arch_idx_t [LANES-1:0]   row_s2   [max_rows];
  logic      [LANES-1:0]   row_cv   [max_rows];
  phys_tag_t [LANES-1:0]   row_ct   [max_rows];
  logic      [LANES-1:0]   row_rv   [max_rows];
  arch_idx_t [LANES-1:0]   row_rar  [max_rows];
  phys_tag_t [LANES-1:0]   row_rt   [max_rows];
  logic                    row_rec  [max_rows];

  // expected columns
  phys_tag_t [LANES-1:0]   exp_s1t  [max_rows];
  logic      [LANES-1:0]   exp_s1r  [max_rows];
  phys_tag_t [LANES-1:0]   exp_s2t  [max_rows];
  logic      [LANES-1:0]   exp_s2r  [max_rows];
  phys_tag_t [LANES-1:0]   exp_dt   [max_rows];
  phys_tag_t [LANES-1:0]   exp_tt   [max_rows];
  logic                    exp_stall [max_rows];
  free_cnt_t               exp_cnt  [max_rows];

  int row_count   = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  rename_unit #(
    .LANES(LANES)
  ) rename_unit_inst (
    .clock       (clock),
    .reset       (reset),
    .dest_valid  (dest_valid),
    .dest_ar     (dest_ar),
    .src1_ar     (src1_ar),
    .src2_ar     (src2_ar),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .retire_valid(retire_valid),
    .retire_ar   (retire_ar),
    .retire_tag  (retire_tag),
    .recover     (recover),
    .src1_tag    (src1_tag),
    .src1_ready  (src1_ready),
    .src2_tag    (src2_tag),
    .src2_ready  (src2_ready),
    .dest_tag    (dest_tag),
    .told_tag    (told_tag),
    .rename_stall(rename_stall),
    .free_count  (free_count)
  );

  always #10 clock = ~clock;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  // run length bounded by the table size
  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      report_failure("the run did not finish within the cycle limit");
    end
  end

  task automatic check_tag(input string test, input string field,
                           input phys_tag_t expected, input phys_tag_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch %s %s: expected %0d, actual %0d",
                               test, field, expected, actual));
    end
  endtask

  task automatic check_bit(input string test, input string field,
                           input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch %s %s: expected %b, actual %b",
                               test, field, expected, actual));
    end
  endtask

  task automatic check_count(input string test, input free_cnt_t expected,
                             input free_cnt_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch %s free_count: expected %0d, actual %0d",
                               test, expected, actual));
    end
  endtask

  // opens a row with its rename group and idle other inputs
  // sources are given lane 1 first
  task automatic new_row(input string name, input logic [1:0] dv, input arch_idx_t d1, d0,
                         input arch_idx_t a1, b1, a0, b0);
    row_name[row_count] = name;
    row_dv[row_count]   = dv;
    row_dar[row_count]  = {d1, d0};
    row_s1[row_count]   = {a1, a0};
    row_s2[row_count]   = {b1, b0};
    row_cv[row_count]   = '0;
    row_ct[row_count]   = '0;
    row_rv[row_count]   = '0;
    row_rar[row_count]  = '0;
    row_rt[row_count]   = '0;
    row_rec[row_count]  = 1'b0;
    row_count = row_count + 1;
  endtask

  task automatic add_cdb(input logic [1:0] v, input phys_tag_t t1, t0);
    row_cv[row_count-1] = v;
    row_ct[row_count-1] = {t1, t0};
  endtask

  task automatic add_retire(input logic [1:0] v, input arch_idx_t a1, a0,
                            input phys_tag_t t1, t0);
    row_rv[row_count-1]  = v;
    row_rar[row_count-1] = {a1, a0};
    row_rt[row_count-1]  = {t1, t0};
  endtask

  task automatic expect_src(input phys_tag_t a1, input logic ar1, input phys_tag_t b1,
                            input logic br1, input phys_tag_t a0, input logic ar0,
                            input phys_tag_t b0, input logic br0);
    exp_s1t[row_count-1] = {a1, a0};
    exp_s1r[row_count-1] = {ar1, ar0};
    exp_s2t[row_count-1] = {b1, b0};
    exp_s2r[row_count-1] = {br1, br0};
  endtask

  task automatic expect_dest(input phys_tag_t d1, d0, t1, t0, input logic stall,
                             input free_cnt_t cnt);
    exp_dt[row_count-1]    = {d1, d0};
    exp_tt[row_count-1]    = {t1, t0};
    exp_stall[row_count-1] = stall;
    exp_cnt[row_count-1]   = cnt;
  endtask

  task automatic build_table();
    new_row("reset_lookup", 2'b00, 0, 0, 1, 2, 3, 15);
    expect_src(1, 1, 2, 1, 3, 1, 15, 1);
    expect_dest(0, 0, 0, 0, 0, 8);
    // lane 0 sees lane 1's new tag for register 1
    new_row("rename_pair", 2'b11, 1, 2, 3, 4, 1, 2);
    expect_src(3, 1, 4, 1, 16, 0, 2, 1);
    expect_dest(16, 17, 1, 2, 0, 8);
    new_row("lookup_new", 2'b00, 0, 0, 1, 2, 2, 5);
    expect_src(16, 0, 17, 0, 17, 0, 5, 1);
    expect_dest(0, 0, 0, 0, 0, 6);
    new_row("cdb_wakeup", 2'b00, 0, 0, 1, 2, 1, 0);
    add_cdb(2'b10, 16, 0);
    expect_src(16, 1, 17, 0, 16, 1, 0, 1);
    expect_dest(0, 0, 0, 0, 0, 6);
    new_row("rename_r0", 2'b10, 0, 0, 1, 2, 0, 1);
    expect_src(16, 1, 17, 0, 18, 1, 16, 1);
    expect_dest(18, 0, 0, 0, 0, 6);
    new_row("r0_ready", 2'b00, 0, 0, 0, 1, 2, 3);
    expect_src(18, 1, 16, 1, 17, 0, 3, 1);
    expect_dest(0, 0, 0, 0, 0, 5);
    new_row("fill_a", 2'b11, 3, 4, 3, 4, 3, 4);
    expect_src(3, 1, 4, 1, 19, 0, 4, 1);
    expect_dest(19, 20, 3, 4, 0, 5);
    new_row("fill_b", 2'b11, 5, 6, 3, 4, 5, 6);
    expect_src(19, 0, 20, 0, 21, 0, 6, 1);
    expect_dest(21, 22, 5, 6, 0, 3);
    // one tag left for two requests
    new_row("stall_two", 2'b11, 7, 8, 7, 8, 7, 8);
    expect_src(7, 1, 8, 1, 7, 1, 8, 1);
    expect_dest(0, 0, 7, 8, 1, 1);
    new_row("stall_holds", 2'b00, 0, 0, 7, 8, 5, 6);
    expect_src(7, 1, 8, 1, 21, 0, 22, 0);
    expect_dest(0, 0, 0, 0, 0, 1);
    new_row("single_dest", 2'b01, 0, 7, 7, 1, 7, 1);
    expect_src(7, 1, 16, 1, 7, 1, 16, 1);
    expect_dest(0, 23, 0, 7, 0, 1);
    new_row("empty_stall", 2'b10, 9, 0, 7, 0, 3, 4);
    expect_src(23, 0, 18, 1, 19, 0, 20, 0);
    expect_dest(0, 0, 9, 0, 1, 0);
    // retiring in allocation order frees tags 1 and 2
    new_row("retire_pair", 2'b00, 0, 0, 1, 2, 0, 7);
    add_cdb(2'b01, 0, 17);
    add_retire(2'b11, 1, 2, 16, 17);
    expect_src(16, 1, 17, 1, 18, 1, 23, 0);
    expect_dest(0, 0, 0, 0, 0, 0);
    new_row("retire_one", 2'b00, 0, 0, 3, 4, 2, 0);
    add_cdb(2'b11, 19, 20);
    add_retire(2'b10, 0, 0, 18, 0);
    expect_src(19, 1, 20, 1, 17, 1, 18, 1);
    expect_dest(0, 0, 0, 0, 0, 2);
    new_row("count_rises", 2'b01, 0, 9, 9, 5, 9, 6);
    expect_src(9, 1, 21, 0, 9, 1, 22, 0);
    expect_dest(0, 1, 0, 9, 0, 3);
    // same-cycle retirement of tag 19 still commits
    new_row("recover_pulse", 2'b11, 10, 11, 1, 9, 10, 0);
    add_retire(2'b10, 3, 0, 19, 0);
    row_rec[row_count-1] = 1'b1;
    expect_src(16, 1, 1, 0, 2, 0, 18, 1);
    expect_dest(2, 0, 10, 11, 0, 2);
    new_row("after_recover", 2'b00, 0, 0, 0, 3, 4, 9);
    expect_src(18, 1, 19, 1, 4, 1, 9, 1);
    expect_dest(0, 0, 0, 0, 0, 8);
    new_row("recover_more", 2'b00, 0, 0, 1, 2, 5, 7);
    expect_src(16, 1, 17, 1, 5, 1, 7, 1);
    expect_dest(0, 0, 0, 0, 0, 8);
    new_row("alloc_after", 2'b11, 5, 6, 5, 6, 5, 1);
    expect_src(5, 1, 6, 1, 20, 0, 16, 1);
    expect_dest(20, 21, 5, 6, 0, 8);
    new_row("final_lookup", 2'b00, 0, 0, 5, 6, 10, 11);
    expect_src(20, 0, 21, 0, 10, 1, 11, 1);
    expect_dest(0, 0, 0, 0, 0, 6);
  endtask

  task automatic apply_row(input int i);
    dest_valid   = row_dv[i];
    dest_ar      = row_dar[i];
    src1_ar      = row_s1[i];
    src2_ar      = row_s2[i];
    cdb_valid    = row_cv[i];
    cdb_tag      = row_ct[i];
    retire_valid = row_rv[i];
    retire_ar    = row_rar[i];
    retire_tag   = row_rt[i];
    recover      = row_rec[i];
  endtask

  task automatic check_row(input int i);
    string n;
    n = row_name[i];
    for (int lane = 0; lane < LANES; lane++) begin
      check_tag(n, $sformatf("src1_tag[%0d]", lane), exp_s1t[i][lane], src1_tag[lane]);
      check_bit(n, $sformatf("src1_ready[%0d]", lane), exp_s1r[i][lane], src1_ready[lane]);
      check_tag(n, $sformatf("src2_tag[%0d]", lane), exp_s2t[i][lane], src2_tag[lane]);
      check_bit(n, $sformatf("src2_ready[%0d]", lane), exp_s2r[i][lane], src2_ready[lane]);
      // dest and told only mean something for a requesting lane
      if (row_dv[i][lane] && !exp_stall[i]) begin
        check_tag(n, $sformatf("dest_tag[%0d]", lane), exp_dt[i][lane], dest_tag[lane]);
      end
      if (row_dv[i][lane]) begin
        check_tag(n, $sformatf("told_tag[%0d]", lane), exp_tt[i][lane], told_tag[lane]);
      end
    end
    check_bit(n, "rename_stall", exp_stall[i], rename_stall);
    check_count(n, exp_cnt[i], free_count);
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    dest_valid   = '0;
    dest_ar      = '0;
    src1_ar      = '0;
    src2_ar      = '0;
    cdb_valid    = '0;
    cdb_tag      = '0;
    retire_valid = '0;
    retire_ar    = '0;
    retire_tag   = '0;
    recover      = 1'b0;
    build_table();
    cycle_limit = 2 * row_count + 20;

    repeat (4) @(posedge clock);
    #2;
    reset = 1'b0;

    // drive after the edge and sample just before the next one
    for (int i = 0; i < row_count; i++) begin
      @(posedge clock);
      #2;
      apply_row(i);
      #16;
      check_row(i);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: verilog/rename_unit.sv
// rename stage top; LANES from 1 to 4, retirement and broadcasts come straight from outside
`timescale 1ns/1ps

module rename_unit
  import rename_pkg::*;
#(
  parameter int LANES = 2
) (
  input  logic                         clock,
  input  logic                         reset,

  // rename group, lane LANES-1 oldest
  input  logic      [LANES-1:0]        dest_valid,
  input  arch_idx_t [LANES-1:0]        dest_ar,
  input  arch_idx_t [LANES-1:0]        src1_ar,
  input  arch_idx_t [LANES-1:0]        src2_ar,

  // completion broadcasts
  input  logic      [LANES-1:0]        cdb_valid,
  input  phys_tag_t [LANES-1:0]        cdb_tag,

  // retirement in program order
  input  logic      [LANES-1:0]        retire_valid,
  input  arch_idx_t [LANES-1:0]        retire_ar,
  input  phys_tag_t [LANES-1:0]        retire_tag,

  // branch recovery strobe
  input  logic                         recover,

  output phys_tag_t [LANES-1:0]        src1_tag,
  output logic      [LANES-1:0]        src1_ready,
  output phys_tag_t [LANES-1:0]        src2_tag,
  output logic      [LANES-1:0]        src2_ready,
  output phys_tag_t [LANES-1:0]        dest_tag,
  output phys_tag_t [LANES-1:0]        told_tag,
  output logic                         rename_stall,
  output free_cnt_t                    free_count
);

  // committed mapping for recovery
  phys_tag_t [arch_count-1:0] arch_map;

  // retirement releases toward the free list
  logic      [LANES-1:0]      freed_valid;
  phys_tag_t [LANES-1:0]      freed_tag;

  map_table #(
    .LANES(LANES)
  ) map_table_inst (
    .clock       (clock),
    .reset       (reset),
    .recover     (recover),
    .arch_map    (arch_map),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .dest_valid  (dest_valid),
    .dest_ar     (dest_ar),
    .alloc_tag   (dest_tag),
    .rename_stall(rename_stall),
    .src1_ar     (src1_ar),
    .src2_ar     (src2_ar),
    .src1_tag    (src1_tag),
    .src2_tag    (src2_tag),
    .src1_ready  (src1_ready),
    .src2_ready  (src2_ready),
    .told_tag    (told_tag)
  );

  arch_map_table #(
    .LANES(LANES)
  ) arch_map_table_inst (
    .clock       (clock),
    .reset       (reset),
    .retire_valid(retire_valid),
    .retire_ar   (retire_ar),
    .retire_tag  (retire_tag),
    .arch_map    (arch_map),
    .freed_valid (freed_valid),
    .freed_tag   (freed_tag)
  );

  // the allocated tags double as the destination tags of the group
  free_list #(
    .LANES(LANES)
  ) free_list_inst (
    .clock       (clock),
    .reset       (reset),
    .recover     (recover),
    .dest_valid  (dest_valid),
    .freed_valid (freed_valid),
    .freed_tag   (freed_tag),
    .alloc_tag   (dest_tag),
    .rename_stall(rename_stall),
    .free_count  (free_count)
  );

endmodule

// File: verilog/free_list.sv
// free tag FIFO; a group allocates all or nothing, a recovery rewinds to the committed read pointer
`timescale 1ns/1ps

module free_list
  import rename_pkg::*;
#(
  parameter int LANES = 2
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         recover,

  // allocation requests
  input  logic      [LANES-1:0]        dest_valid,

  // tags returned by retirement
  input  logic      [LANES-1:0]        freed_valid,
  input  phys_tag_t [LANES-1:0]        freed_tag,

  output phys_tag_t [LANES-1:0]        alloc_tag,
  output logic                         rename_stall,
  output free_cnt_t                    free_count
);

  localparam int ptr_w = $clog2(free_depth);

  // one extra wrap bit so a full list differs from an empty one
  typedef logic [ptr_w:0] ptr_t;

  phys_tag_t [free_depth-1:0] slot_q;
  phys_tag_t [free_depth-1:0] slot_next;
  ptr_t                       rd_q;
  ptr_t                       wr_q;
  ptr_t                       commit_q;
  ptr_t                       wr_next;
  ptr_t                       commit_next;
  free_cnt_t                  count_q;
  int                         need;
  int                         freed_cnt;

  // hand out tags in order, oldest requesting lane first
  always_comb begin
    ptr_t pos;
    pos  = rd_q;
    need = 0;
    for (int lane = LANES - 1; lane >= 0; lane--) begin
      alloc_tag[lane] = slot_q[pos[ptr_w-1:0]];
      if (dest_valid[lane]) begin
        pos  = pos + 1'b1;
        need = need + 1;
      end
    end
  end

  // stall when the registered count cannot cover the whole group
  assign rename_stall = need > int'(count_q);
  assign free_count   = count_q;

  // append released tags in lane order
  always_comb begin
    slot_next = slot_q;
    wr_next   = wr_q;
    freed_cnt = 0;
    for (int lane = LANES - 1; lane >= 0; lane--) begin
      if (freed_valid[lane]) begin
        slot_next[wr_next[ptr_w-1:0]] = freed_tag[lane];
        wr_next   = wr_next + 1'b1;
        freed_cnt = freed_cnt + 1;
      end
    end
    // one committed allocation per retirement
    commit_next = commit_q + ptr_t'(freed_cnt);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // tags above the identity mapping start out free
      for (int i = 0; i < free_depth; i++) begin
        slot_q[i] <= phys_tag_t'(arch_count + i);
      end
      rd_q     <= '0;
      wr_q     <= ptr_t'(free_depth);
      commit_q <= '0;
      count_q  <= free_cnt_t'(free_depth);
    end else begin
      slot_q   <= slot_next;
      wr_q     <= wr_next;
      commit_q <= commit_next;
      if (recover) begin
        // speculative allocations are dropped, retirements still count
        rd_q    <= commit_next;
        count_q <= free_cnt_t'(wr_next - commit_next);
      end else if (rename_stall) begin
        count_q <= count_q + free_cnt_t'(freed_cnt);
      end else begin
        rd_q    <= rd_q + ptr_t'(need);
        count_q <= count_q - free_cnt_t'(need) + free_cnt_t'(freed_cnt);
      end
    end
  end

endmodule

// File: verilog/arch_map_table.sv
// committed map; retirements must arrive in program order with lane LANES-1 the oldest
`timescale 1ns/1ps

module arch_map_table
  import rename_pkg::*;
#(
  parameter int LANES = 2
) (
  input  logic                         clock,
  input  logic                         reset,

  // retirements for this cycle
  input  logic      [LANES-1:0]        retire_valid,
  input  arch_idx_t [LANES-1:0]        retire_ar,
  input  phys_tag_t [LANES-1:0]        retire_tag,

  // mapping after this cycle's commits, used for recovery
  output phys_tag_t [arch_count-1:0]   arch_map,

  // tags released by the retirements
  output logic      [LANES-1:0]        freed_valid,
  output phys_tag_t [LANES-1:0]        freed_tag
);

  phys_tag_t [arch_count-1:0] commit_q;
  phys_tag_t [arch_count-1:0] commit_next;

  // apply retirements oldest first, each lane frees whatever it overwrites
  always_comb begin
    commit_next = commit_q;
    for (int lane = LANES - 1; lane >= 0; lane--) begin
      // an older lane of the same group may already have replaced this entry
      freed_tag[lane] = commit_next[retire_ar[lane]];
      if (retire_valid[lane]) begin
        commit_next[retire_ar[lane]] = retire_tag[lane];
      end
    end
  end

  // every retirement releases exactly one tag
  assign freed_valid = retire_valid;
  assign arch_map    = commit_next;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < arch_count; i++) begin
        commit_q[i] <= phys_tag_t'(i);
      end
    end else begin
      commit_q <= commit_next;
    end
  end

endmodule

// File: verilog/map_table.sv
// speculative map; lane LANES-1 is oldest, source lookups see older lanes and this cycle's broadcasts
`timescale 1ns/1ps

module map_table
  import rename_pkg::*;
#(
  parameter int LANES = 2
) (
  input  logic                         clock,
  input  logic                         reset,

  // recovery copies the committed mapping at the next edge
  input  logic                         recover,
  input  phys_tag_t [arch_count-1:0]   arch_map,

  // completion broadcasts
  input  logic      [LANES-1:0]        cdb_valid,
  input  phys_tag_t [LANES-1:0]        cdb_tag,

  // destination renames
  input  logic      [LANES-1:0]        dest_valid,
  input  arch_idx_t [LANES-1:0]        dest_ar,
  input  phys_tag_t [LANES-1:0]        alloc_tag,
  input  logic                         rename_stall,

  // source lookups
  input  arch_idx_t [LANES-1:0]        src1_ar,
  input  arch_idx_t [LANES-1:0]        src2_ar,
  output phys_tag_t [LANES-1:0]        src1_tag,
  output phys_tag_t [LANES-1:0]        src2_tag,
  output logic      [LANES-1:0]        src1_ready,
  output logic      [LANES-1:0]        src2_ready,

  // mapping overwritten by each lane's destination
  output phys_tag_t [LANES-1:0]        told_tag
);

  // registered mapping and ready bits
  phys_tag_t [arch_count-1:0] map_q;
  logic      [arch_count-1:0] ready_q;

  // stage LANES is the woken current state, stage 0 carries every rename of the group
  phys_tag_t [arch_count-1:0] stage_map   [LANES+1];
  logic      [arch_count-1:0] stage_ready [LANES+1];

  // true when any valid broadcast carries this tag, tag 0 never matches
  function automatic logic cdb_match(input phys_tag_t tag);
    logic hit;
    hit = 1'b0;
    if (tag != '0) begin
      for (int c = 0; c < LANES; c++) begin
        if (cdb_valid[c] && (cdb_tag[c] == tag)) begin
          hit = 1'b1;
        end
      end
    end
    return hit;
  endfunction

  // next-state build: wakeup first, then renames oldest to youngest
  always_comb begin
    for (int r = 0; r < arch_count; r++) begin
      stage_map[LANES][r]   = map_q[r];
      stage_ready[LANES][r] = ready_q[r] | cdb_match(map_q[r]);
    end

    for (int lane = LANES - 1; lane >= 0; lane--) begin
      stage_map[lane]   = stage_map[lane+1];
      stage_ready[lane] = stage_ready[lane+1];
      if (dest_valid[lane] && !rename_stall) begin
        stage_map[lane][dest_ar[lane]] = alloc_tag[lane];
        // register 0 is hardwired, so it never waits on a producer
        if (dest_ar[lane] != '0) begin
          stage_ready[lane][dest_ar[lane]] = 1'b0;
        end
      end
    end
  end

  // each lane reads the stage just older than itself
  always_comb begin
    for (int lane = 0; lane < LANES; lane++) begin
      src1_tag[lane]   = stage_map[lane+1][src1_ar[lane]];
      src2_tag[lane]   = stage_map[lane+1][src2_ar[lane]];
      src1_ready[lane] = stage_ready[lane+1][src1_ar[lane]];
      src2_ready[lane] = stage_ready[lane+1][src2_ar[lane]];
    end
  end

  // start-of-cycle mapping of each destination
  always_comb begin
    for (int lane = 0; lane < LANES; lane++) begin
      told_tag[lane] = map_q[dest_ar[lane]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity mapping, everything ready
      for (int i = 0; i < arch_count; i++) begin
        map_q[i] <= phys_tag_t'(i);
      end
      ready_q <= '1;
    end else if (recover) begin
      // committed values are ready by definition
      map_q   <= arch_map;
      ready_q <= '1;
    end else begin
      map_q   <= stage_map[0];
      ready_q <= stage_ready[0];
    end
  end

endmodule

// File: verilog/rename_pkg.sv
// sizes are fixed here for all blocks; free_depth must stay a power of two for the free list
package rename_pkg;

  // architectural and physical register file sizes
  localparam int arch_count = 16;
  localparam int phys_count = 24;

  // every physical register outside the committed map sits in the free list
  localparam int free_depth = phys_count - arch_count;

  // field widths derived from the sizes
  localparam int arch_w = $clog2(arch_count);
  localparam int phys_w = $clog2(phys_count);
  localparam int cnt_w  = $clog2(free_depth + 1);

  // architectural register index
  typedef logic [arch_w-1:0] arch_idx_t;

  // physical register tag
  // tag 0 never matches on the broadcast bus
  typedef logic [phys_w-1:0] phys_tag_t;

  // number of free entries, 0 up to free_depth
  typedef logic [cnt_w-1:0] free_cnt_t;

endpackage
